// ==== hdl/vgaText_config.svh ====
`ifndef VGATEXT_CONFIG_SVH
`define VGATEXT_CONFIG_SVH

// 640x480 raster, in pixel clocks.
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define GLYPH_SIZE 8
`define WIN_CELLS 16
`define WIN_SIZE (`WIN_CELLS * `GLYPH_SIZE)

`define REG_CTRL 8'h00
`define REG_ORIGIN 8'h04
`define REG_FG 8'h08
`define REG_BG 8'h0C
`define REG_BACKDROP 8'h10

`define RENDER_LATENCY 4

`endif

// ==== hdl/vgaText_pkg.sv ====
`default_nettype none

package vgaText_pkg;

    // ASCII-valued character code.
    typedef logic [6:0] charCode_t;
    // Window cell, row in the upper nibble.
    typedef logic [7:0] charXy_t;
    // Leftmost pixel in the MSB.
    typedef logic [7:0] glyphLine_t;
    typedef logic [11:0] rgb_t;
    typedef logic [9:0] coord_t;
    typedef logic [7:0] apbAddr_t;
    typedef logic [31:0] apbData_t;

    localparam charCode_t SPACE = 7'h20;
    localparam charCode_t NKL = 7'h5B;
    localparam charCode_t NKR = 7'h5D;

    localparam charCode_t
        C_0 = 7'h30, C_1 = 7'h31, C_2 = 7'h32, C_3 = 7'h33, C_4 = 7'h34,
        C_5 = 7'h35, C_6 = 7'h36, C_7 = 7'h37, C_8 = 7'h38, C_9 = 7'h39;

    localparam charCode_t
        A = 7'h41, B = 7'h42, C = 7'h43, D = 7'h44, E = 7'h45,
        F = 7'h46, G = 7'h47, H = 7'h48, I = 7'h49, J = 7'h4A,
        K = 7'h4B, L = 7'h4C, M = 7'h4D, N = 7'h4E, O = 7'h4F,
        P = 7'h50, Q = 7'h51, R = 7'h52, S = 7'h53, T = 7'h54,
        U = 7'h55, V = 7'h56, W = 7'h57, X = 7'h58, Y = 7'h59,
        Z = 7'h5A;

endpackage

`default_nettype wire

// ==== hdl/vgaTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaText_config.svh"

module vgaTiming (
    input  logic                clk,
    input  logic                rst,
    output vgaText_pkg::coord_t hCount,
    output vgaText_pkg::coord_t vCount,
    output logic                hsyncRaw,
    output logic                vsyncRaw,
    output logic                active
);

    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END = VS_START + `V_SYNC;

    logic lineEnd;
    logic frameEnd;

    assign lineEnd = (hCount == vgaText_pkg::coord_t'(`H_TOTAL - 1));
    assign frameEnd = (vCount == vgaText_pkg::coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Vertical steps once per line.
    always_ff @(posedge clk) begin
        if (rst) begin
            vCount <= '0;
        end else if (lineEnd) begin
            if (frameEnd) begin
                vCount <= '0;
            end else begin
                vCount <= vCount + 1'b1;
            end
        end
    end

    // Active low sync pulses.
    assign hsyncRaw = !((hCount >= vgaText_pkg::coord_t'(HS_START))
                        && (hCount < vgaText_pkg::coord_t'(HS_END)));
    assign vsyncRaw = !((vCount >= vgaText_pkg::coord_t'(VS_START))
                        && (vCount < vgaText_pkg::coord_t'(VS_END)));

    assign active = (hCount < vgaText_pkg::coord_t'(`H_ACTIVE))
                    && (vCount < vgaText_pkg::coord_t'(`V_ACTIVE));

endmodule

`default_nettype wire

// ==== hdl/apbRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaText_config.svh"

module apbRegs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  vgaText_pkg::apbAddr_t paddr,
    input  vgaText_pkg::apbData_t pwdata,
    output vgaText_pkg::apbData_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  enable,
    output vgaText_pkg::coord_t   originX,
    output vgaText_pkg::coord_t   originY,
    output vgaText_pkg::rgb_t     fgColor,
    output vgaText_pkg::rgb_t     bgColor,
    output vgaText_pkg::rgb_t     backdropColor
);

    logic mapped;
    logic wrEn;

    // Read mux and address decode.
    always_comb begin
        mapped = 1'b1;
        case (paddr)
            `REG_CTRL:     prdata = {31'b0, enable};
            `REG_ORIGIN:   prdata = {6'b0, originY, 6'b0, originX};
            `REG_FG:       prdata = {20'b0, fgColor};
            `REG_BG:       prdata = {20'b0, bgColor};
            `REG_BACKDROP: prdata = {20'b0, backdropColor};
            default: begin
                mapped = 1'b0;
                prdata = '0;
            end
        endcase
    end

    // No wait states.
    assign pready = psel;
    assign pslverr = psel && penable && !mapped;
    assign wrEn = psel && penable && pwrite && mapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            originX <= '0;
            originY <= '0;
            fgColor <= '0;
            bgColor <= '0;
            backdropColor <= '0;
        end else if (wrEn) begin
            case (paddr)
                `REG_CTRL: enable <= pwdata[0];
                `REG_ORIGIN: begin
                    originX <= pwdata[9:0];
                    originY <= pwdata[25:16];
                end
                `REG_FG: fgColor <= pwdata[11:0];
                `REG_BG: bgColor <= pwdata[11:0];
                default: backdropColor <= pwdata[11:0];
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/textMessage.sv ====
`timescale 1ns/1ps
`default_nettype none

module textMessage (
    input  logic                   clk,
    input  logic                   rst,
    input  vgaText_pkg::charXy_t   charXy,
    output vgaText_pkg::charCode_t charCode
);

    vgaText_pkg::charCode_t data;

    always_ff @(posedge clk) begin
        if (rst) begin
            charCode <= '0;
        end else begin
            charCode <= data;
        end
    end

    always_comb begin
        case (charXy)
            // Title row.
            8'h00: data = vgaText_pkg::V;
            8'h01: data = vgaText_pkg::G;
            8'h02: data = vgaText_pkg::A;
            8'h04: data = vgaText_pkg::T;
            8'h05: data = vgaText_pkg::E;
            8'h06: data = vgaText_pkg::X;
            8'h07: data = vgaText_pkg::T;
            8'h20: data = vgaText_pkg::R;
            8'h21: data = vgaText_pkg::A;
            8'h22: data = vgaText_pkg::S;
            8'h23: data = vgaText_pkg::T;
            8'h24: data = vgaText_pkg::E;
            8'h25: data = vgaText_pkg::R;
            8'h26: data = vgaText_pkg::S;
            8'h27: data = vgaText_pkg::C;
            8'h28: data = vgaText_pkg::A;
            8'h29: data = vgaText_pkg::N;
            // Numbered entries.
            8'h61: data = vgaText_pkg::NKL;
            8'h62: data = vgaText_pkg::C_1;
            8'h63: data = vgaText_pkg::NKR;
            8'h65: data = vgaText_pkg::O;
            8'h66: data = vgaText_pkg::V;
            8'h67: data = vgaText_pkg::E;
            8'h68: data = vgaText_pkg::R;
            8'h69: data = vgaText_pkg::L;
            8'h6A: data = vgaText_pkg::A;
            8'h6B: data = vgaText_pkg::Y;
            8'h71: data = vgaText_pkg::NKL;
            8'h72: data = vgaText_pkg::C_2;
            8'h73: data = vgaText_pkg::NKR;
            8'h75: data = vgaText_pkg::R;
            8'h76: data = vgaText_pkg::E;
            8'h77: data = vgaText_pkg::A;
            8'h78: data = vgaText_pkg::D;
            8'h79: data = vgaText_pkg::Y;
            default: data = vgaText_pkg::SPACE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/fontRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module fontRom (
    input  logic                    clk,
    input  logic                    rst,
    input  vgaText_pkg::charCode_t  charCode,
    input  logic [2:0]              glyphRow,
    output vgaText_pkg::glyphLine_t glyphLine
);

    // Whole glyph, top row in the upper byte.
    logic [63:0] glyph;

    always_comb begin
        case (charCode)
            vgaText_pkg::A:   glyph = 64'h183C66667E666600;
            vgaText_pkg::B:   glyph = 64'h7C66667C66667C00;
            vgaText_pkg::C:   glyph = 64'h3C66606060663C00;
            vgaText_pkg::D:   glyph = 64'h786C6666666C7800;
            vgaText_pkg::E:   glyph = 64'h7E60607C60607E00;
            vgaText_pkg::F:   glyph = 64'h7E60607C60606000;
            vgaText_pkg::G:   glyph = 64'h3C66606E66663C00;
            vgaText_pkg::H:   glyph = 64'h6666667E66666600;
            vgaText_pkg::I:   glyph = 64'h3C18181818183C00;
            vgaText_pkg::J:   glyph = 64'h1E0C0C0C0C6C3800;
            vgaText_pkg::K:   glyph = 64'h666C7870786C6600;
            vgaText_pkg::L:   glyph = 64'h6060606060607E00;
            vgaText_pkg::M:   glyph = 64'h63777F6B63636300;
            vgaText_pkg::N:   glyph = 64'h66767E7E6E666600;
            vgaText_pkg::O:   glyph = 64'h3C66666666663C00;
            vgaText_pkg::P:   glyph = 64'h7C66667C60606000;
            vgaText_pkg::Q:   glyph = 64'h3C666666663C0E00;
            vgaText_pkg::R:   glyph = 64'h7C66667C786C6600;
            vgaText_pkg::S:   glyph = 64'h3C66603C06663C00;
            vgaText_pkg::T:   glyph = 64'h7E18181818181800;
            vgaText_pkg::U:   glyph = 64'h6666666666663C00;
            vgaText_pkg::V:   glyph = 64'h66666666663C1800;
            vgaText_pkg::W:   glyph = 64'h6363636B7F776300;
            vgaText_pkg::X:   glyph = 64'h66663C183C666600;
            vgaText_pkg::Y:   glyph = 64'h6666663C18181800;
            vgaText_pkg::Z:   glyph = 64'h7E060C1830607E00;
            vgaText_pkg::C_0: glyph = 64'h3C666E7666663C00;
            vgaText_pkg::C_1: glyph = 64'h1838181818187E00;
            vgaText_pkg::C_2: glyph = 64'h3C66060C30607E00;
            vgaText_pkg::C_3: glyph = 64'h3C66061C06663C00;
            vgaText_pkg::C_4: glyph = 64'h060E1E667F060600;
            vgaText_pkg::C_5: glyph = 64'h7E607C0606663C00;
            vgaText_pkg::C_6: glyph = 64'h3C66607C66663C00;
            vgaText_pkg::C_7: glyph = 64'h7E660C1818181800;
            vgaText_pkg::C_8: glyph = 64'h3C66663C66663C00;
            vgaText_pkg::C_9: glyph = 64'h3C66663E06663C00;
            vgaText_pkg::NKL: glyph = 64'h3C30303030303C00;
            vgaText_pkg::NKR: glyph = 64'h3C0C0C0C0C0C3C00;
            // Space and anything unsupported stay blank.
            default:          glyph = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            glyphLine <= '0;
        end else begin
            glyphLine <= glyph[{3'd7 - glyphRow, 3'b000} +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/textRender.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaText_config.svh"

module textRender (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  vgaText_pkg::coord_t hCount,
    input  vgaText_pkg::coord_t vCount,
    input  vgaText_pkg::coord_t originX,
    input  vgaText_pkg::coord_t originY,
    input  logic                hsyncRaw,
    input  logic                vsyncRaw,
    input  logic                active,
    input  vgaText_pkg::rgb_t   fgColor,
    input  vgaText_pkg::rgb_t   bgColor,
    input  vgaText_pkg::rgb_t   backdropColor,
    output logic                hsync,
    output logic                vsync,
    output vgaText_pkg::rgb_t   rgb
);

    vgaText_pkg::coord_t relX;
    vgaText_pkg::coord_t relY;
    logic inWin;
    // Flag pipes, bit 0 is stage 1.
    logic [2:0] hsDly;
    logic [2:0] vsDly;
    logic [2:0] actDly;
    logic [2:0] winDly;
    vgaText_pkg::charXy_t charXy1;
    logic [2:0] row1;
    logic [2:0] row2;
    logic [2:0] col1;
    logic [2:0] col2;
    logic [2:0] col3;
    vgaText_pkg::rgb_t fgPipe [1:3];
    vgaText_pkg::rgb_t bgPipe [1:3];
    vgaText_pkg::rgb_t bdPipe [1:3];
    vgaText_pkg::charCode_t charCode;
    vgaText_pkg::glyphLine_t glyphLine;

    assign relX = hCount - originX;
    assign relY = vCount - originY;
    assign inWin = enable
                   && (hCount >= originX) && (relX < vgaText_pkg::coord_t'(`WIN_SIZE))
                   && (vCount >= originY) && (relY < vgaText_pkg::coord_t'(`WIN_SIZE));

    always_ff @(posedge clk) begin
        if (rst) begin
            hsDly <= '1;
            vsDly <= '1;
            actDly <= '0;
            winDly <= '0;
        end else begin
            hsDly <= {hsDly[1:0], hsyncRaw};
            vsDly <= {vsDly[1:0], vsyncRaw};
            actDly <= {actDly[1:0], active};
            winDly <= {winDly[1:0], inWin};
        end
    end

    // Cell address, glyph indices and colours follow the pixel.
    always_ff @(posedge clk) begin
        charXy1 <= {relY[6:3], relX[6:3]};
        row1 <= relY[2:0];
        row2 <= row1;
        col1 <= relX[2:0];
        col2 <= col1;
        col3 <= col2;
        fgPipe <= '{fgColor, fgPipe[1], fgPipe[2]};
        bgPipe <= '{bgColor, bgPipe[1], bgPipe[2]};
        bdPipe <= '{backdropColor, bdPipe[1], bdPipe[2]};
    end

    textMessage message (.clk(clk), .rst(rst), .charXy(charXy1), .charCode(charCode));

    fontRom font (
        .clk(clk),
        .rst(rst),
        .charCode(charCode),
        .glyphRow(row2),
        .glyphLine(glyphLine)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb <= '0;
        end else begin
            hsync <= hsDly[2];
            vsync <= vsDly[2];
            if (!actDly[2]) begin
                rgb <= '0;
            end else if (!winDly[2]) begin
                rgb <= bdPipe[3];
            end else if (glyphLine[3'd7 - col3]) begin
                rgb <= fgPipe[3];
            end else begin
                rgb <= bgPipe[3];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vgaTextTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module vgaTextTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  vgaText_pkg::apbAddr_t paddr,
    input  vgaText_pkg::apbData_t pwdata,
    output vgaText_pkg::apbData_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  hsync,
    output logic                  vsync,
    output vgaText_pkg::rgb_t     rgb
);

    vgaText_pkg::coord_t hCount;
    vgaText_pkg::coord_t vCount;
    logic hsyncRaw;
    logic vsyncRaw;
    logic active;
    logic enable;
    vgaText_pkg::coord_t originX;
    vgaText_pkg::coord_t originY;
    vgaText_pkg::rgb_t fgColor;
    vgaText_pkg::rgb_t bgColor;
    vgaText_pkg::rgb_t backdropColor;

    vgaTiming timing (
        .clk(clk), .rst(rst), .hCount(hCount), .vCount(vCount),
        .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw), .active(active)
    );

    apbRegs regs (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .enable(enable), .originX(originX), .originY(originY),
        .fgColor(fgColor), .bgColor(bgColor), .backdropColor(backdropColor)
    );

    textRender render (
        .clk(clk), .rst(rst), .enable(enable), .hCount(hCount), .vCount(vCount),
        .originX(originX), .originY(originY), .hsyncRaw(hsyncRaw),
        .vsyncRaw(vsyncRaw), .active(active), .fgColor(fgColor), .bgColor(bgColor),
        .backdropColor(backdropColor), .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

endmodule

`default_nettype wire

// ==== bench/vgaTextTop_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaText_config.svh"

module vgaTextTop_assert (
    input logic              clk,
    input logic              rst,
    input logic              psel,
    input logic              pready,
    input logic              hsync,
    input logic              active,
    input vgaText_pkg::rgb_t rgb
);

    logic [7:0] lowCount;
    // Active flag lined up with the output pixel.
    logic [3:0] actPipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            lowCount <= '0;
            actPipe <= '0;
        end else begin
            lowCount <= hsync ? 8'd0 : lowCount + 8'd1;
            actPipe <= {actPipe[2:0], active};
        end
    end

    readyWithSel: assert property (@(posedge clk) disable iff (rst) psel |-> pready)
        else $error("pready low while psel high");

    syncWidth: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> (lowCount == 8'(`H_SYNC)))
        else $error("hsync pulse width differs from H_SYNC");

    blankIsBlack: assert property (@(posedge clk) disable iff (rst) !actPipe[3] |-> (rgb == '0))
        else $error("rgb not black outside the active area");

endmodule

bind vgaTextTop vgaTextTop_assert checks (
    .clk(clk), .rst(rst), .psel(psel), .pready(pready),
    .hsync(hsync), .active(active), .rgb(rgb)
);

`default_nettype wire

// ==== bench/vgaTextTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaText_config.svh"

module vgaTextTb;

    localparam int WAIT_LIMIT = `H_TOTAL * `V_TOTAL + 2 * `H_TOTAL;
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam vgaText_pkg::apbAddr_t REGS [5] =
        '{`REG_CTRL, `REG_ORIGIN, `REG_FG, `REG_BG, `REG_BACKDROP};

    logic clk, rst, psel, penable, pwrite, pready, pslverr, hsync, vsync;
    vgaText_pkg::apbAddr_t paddr;
    vgaText_pkg::apbData_t pwdata, prdata;
    vgaText_pkg::rgb_t rgb;
    // Colours and origin the DUT should hold.
    vgaText_pkg::rgb_t fg, bg, bd;
    int ox, oy;

    vgaTextTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkRgb(input vgaText_pkg::rgb_t got, exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkData(input vgaText_pkg::apbData_t got, exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkFlag(input logic got, exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // One APB setup and access phase.
    task automatic apbTransfer(input logic write, input vgaText_pkg::apbAddr_t addr,
                               input vgaText_pkg::apbData_t data,
                               output vgaText_pkg::apbData_t rdata, output logic err);
        int waited = 0;
        @(posedge clk);
        #2;
        psel = 1'b1;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            waited++;
            if (waited > 16) stopRun("APB slave never raised pready");
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #2;
        {psel, penable, pwrite} = 3'b000;
    endtask

    task automatic writeReg(input vgaText_pkg::apbAddr_t addr,
                            input vgaText_pkg::apbData_t data, input logic expErr);
        vgaText_pkg::apbData_t unused;
        logic err;
        apbTransfer(1'b1, addr, data, unused, err);
        checkFlag(err, expErr, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic readCheck(input vgaText_pkg::apbAddr_t addr,
                             input vgaText_pkg::apbData_t exp, input logic expErr);
        vgaText_pkg::apbData_t got;
        logic err;
        apbTransfer(1'b0, addr, '0, got, err);
        checkFlag(err, expErr, $sformatf("pslverr on read of %h", addr));
        checkData(got, exp, $sformatf("read data of %h", addr));
    endtask

    function automatic vgaText_pkg::apbData_t fieldMask(input vgaText_pkg::apbAddr_t addr);
        case (addr)
            `REG_CTRL: return 32'h0000_0001;
            `REG_ORIGIN: return 32'h03FF_03FF;
            default: return 32'h0000_0FFF;
        endcase
    endfunction

    // Message text by window row.
    function automatic logic cellHasGlyph(input int row, input int col);
        string line;
        case (row)
            0: line = "VGA TEXT";
            2: line = "RASTERSCAN";
            6: line = " [1] OVERLAY";
            7: line = " [2] READY";
            default: line = "";
        endcase
        return (col < line.len()) && (line.getc(col) != 8'h20);
    endfunction

    // Checks a whole frame, counted from the vsync falling edge.
    task automatic captureFrame(input logic win);
        bit [15:0] seen [16];
        logic lastVs = 1'b0;
        bit inWin;
        int x;
        int y;
        int n = 0;
        seen = '{default: '0};
        @(negedge clk);
        while (!(lastVs && !vsync)) begin
            n++;
            if (n > WAIT_LIMIT) stopRun("no vsync falling edge within a frame");
            lastVs = vsync;
            @(negedge clk);
        end
        x = 0;
        y = VS_START;
        for (n = 0; n < `H_TOTAL * `V_TOTAL; n++) begin
            checkFlag(hsync, !(x >= HS_START && x < HS_START + `H_SYNC), "hsync");
            checkFlag(vsync, !(y >= VS_START && y < VS_START + `V_SYNC), "vsync");
            inWin = win && x >= ox && x < ox + `WIN_SIZE && y >= oy && y < oy + `WIN_SIZE;
            if (x >= `H_ACTIVE || y >= `V_ACTIVE) begin
                checkRgb(rgb, '0, "blanking pixel");
            end else if (inWin) begin
                checkFlag(rgb === fg || rgb === bg, 1'b1, "window pixel in fg or bg");
                if (rgb === fg) seen[(y - oy) / `GLYPH_SIZE][(x - ox) / `GLYPH_SIZE] = 1'b1;
            end else begin
                checkRgb(rgb, bd, "backdrop pixel");
            end
            x++;
            if (x == `H_TOTAL) begin
                x = 0;
                y = (y + 1) % `V_TOTAL;
            end
            @(negedge clk);
        end
        for (int r = 0; win && r < `WIN_CELLS; r++) begin
            for (int c = 0; c < `WIN_CELLS; c++) begin
                checkFlag(seen[r][c], cellHasGlyph(r, c), $sformatf("fg in cell %0d,%0d", r, c));
            end
        end
    endtask

    task automatic newColors();
        fg = vgaText_pkg::rgb_t'($urandom);
        do bg = vgaText_pkg::rgb_t'($urandom); while (bg == fg);
        do bd = vgaText_pkg::rgb_t'($urandom); while (bd == fg || bd == bg);
        writeReg(`REG_FG, fg, 1'b0);
        writeReg(`REG_BG, bg, 1'b0);
        writeReg(`REG_BACKDROP, bd, 1'b0);
    endtask

    task automatic setOrigin(input int x, input int y);
        ox = x;
        oy = y;
        writeReg(`REG_ORIGIN, {6'b0, 10'(y), 6'b0, 10'(x)}, 1'b0);
    endtask

    task automatic resetTest();
        foreach (REGS[i]) readCheck(REGS[i], '0, 1'b0);
        captureFrame(1'b0);
    endtask

    // Unmapped access must leave the real registers alone.
    task automatic registerTest();
        vgaText_pkg::apbData_t written [5];
        foreach (REGS[i]) begin
            written[i] = $urandom;
            // Every field off its reset value.
            if ((written[i] & fieldMask(REGS[i])) == '0) written[i] = ~written[i];
            writeReg(REGS[i], written[i], 1'b0);
        end
        writeReg(8'h14, $urandom, 1'b1);
        readCheck(8'h14, '0, 1'b1);
        foreach (REGS[i]) readCheck(REGS[i], written[i] & fieldMask(REGS[i]), 1'b0);
    endtask

    task automatic disabledTest();
        writeReg(`REG_CTRL, 32'h0, 1'b0);
        newColors();
        setOrigin($urandom % (`H_ACTIVE - `WIN_SIZE + 1), $urandom % (`V_ACTIVE - `WIN_SIZE + 1));
        captureFrame(1'b0);
    endtask

    task automatic windowTest();
        newColors();
        setOrigin($urandom % (`H_ACTIVE - `WIN_SIZE + 1), $urandom % (`V_ACTIVE - `WIN_SIZE + 1));
        writeReg(`REG_CTRL, 32'h1, 1'b0);
        captureFrame(1'b1);
    endtask

    task automatic moveTest();
        int dx;
        int dy;
        dx = int'($urandom % 64) - 32;
        dy = int'($urandom % 64) - 32;
        // Nonzero step on both axes.
        if (dx >= 0) dx++;
        if (dy >= 0) dy++;
        if (ox + dx < 0 || ox + dx > `H_ACTIVE - `WIN_SIZE) dx = -dx;
        if (oy + dy < 0 || oy + dy > `V_ACTIVE - `WIN_SIZE) dy = -dy;
        setOrigin(ox + dx, oy + dy);
        captureFrame(1'b1);
    endtask

    initial begin
        {psel, penable, pwrite} = 3'b000;
        paddr = '0;
        pwdata = '0;
        {fg, bg, bd} = '0;
        ox = 0;
        oy = 0;
        rst = 1'b1;
        void'($urandom(32'h2faf));
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        resetTest();
        registerTest();
        disabledTest();
        windowTest();
        moveTest();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vgaTextTop.f ====
+incdir+hdl
hdl/vgaText_pkg.sv
hdl/vgaTiming.sv
hdl/apbRegs.sv
hdl/textMessage.sv
hdl/fontRom.sv
hdl/textRender.sv
hdl/vgaTextTop.sv
bench/vgaTextTop_assert.sv
bench/vgaTextTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= vgaTextTb
FLIST ?= vgaTextTop.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	-$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
